// ==== Makefile ====
# Verilator build and run for the memory stage testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== mem_data_ram.sv ====
// Doubleword data RAM with byte-lane writes and a registered read port.
// Reads return the contents from before a write on the same edge.
`timescale 1ns/1ps

module mem_data_ram (
  input  logic                           clk,
  input  logic                           i_accept,
  input  logic                           i_ren,
  input  logic [mem_pkg::RAM_IDX_W-1:0]  i_idx,
  input  logic [mem_pkg::BE_W-1:0]       i_be,
  input  mem_pkg::mem_word_u             i_wword,
  output mem_pkg::mem_word_u             o_rword
);
  import mem_pkg::*;

  logic [XLEN-1:0] mem [RAM_DEPTH];
  mem_word_u       rword_q;

  // Read data only moves on an accepted load, so it holds while the item waits
  always_ff @(posedge clk) begin
    if (i_accept && i_ren) begin
      rword_q.d <= mem[i_idx];
    end
  end

  always_ff @(posedge clk) begin
    for (int lane = 0; lane < BE_W; lane++) begin
      if (i_be[lane]) begin
        mem[i_idx][8*lane +: 8] <= i_wword.b[lane];
      end
    end
  end

  assign o_rword = rword_q;

endmodule

// ==== mem_load_extract.sv ====
// Load extraction: selects the addressed lane of the read word and extends it.
`timescale 1ns/1ps

module mem_load_extract (
  input  logic                           i_ld_valid,
  input  logic [mem_pkg::ADDR_LO_W-1:0]  i_addr_lo,
  input  mem_pkg::funct3_t               i_funct3,
  input  mem_pkg::mem_word_u             i_rword,
  output mem_pkg::xlen_t                 o_rdata
);
  import mem_pkg::*;

  logic [7:0]  byte_lane;
  logic [15:0] half_lane;
  logic [31:0] word_lane;
  xlen_t       ext_data;

  assign byte_lane = i_rword.b[i_addr_lo];
  assign half_lane = i_rword.h[i_addr_lo[2:1]];
  assign word_lane = i_rword.w[i_addr_lo[2]];

  always_comb begin
    case (i_funct3)
      F3_LB:   ext_data = {{56{byte_lane[7]}}, byte_lane};
      F3_LBU:  ext_data = {56'd0, byte_lane};
      F3_LH:   ext_data = {{48{half_lane[15]}}, half_lane};
      F3_LHU:  ext_data = {48'd0, half_lane};
      F3_LW:   ext_data = {{32{word_lane[31]}}, word_lane};
      F3_LWU:  ext_data = {32'd0, word_lane};
      F3_LD:   ext_data = i_rword.d;
      default: ext_data = '0;
    endcase
  end

  // Non-loads and empty slots read as zero
  assign o_rdata = i_ld_valid ? ext_data : '0;

  always_comb begin
    if (i_ld_valid) begin
      load_aligned: assert final (mem_is_aligned(i_funct3, i_addr_lo));
    end
  end

endmodule

// ==== mem_pkg.sv ====
// Shared widths, funct3 codes and the memory word type for the memory stage.
// Import inside a module body, or use scoped names in a module header.
package mem_pkg;

  localparam int XLEN      = 64;
  localparam int INST_W    = 32;
  localparam int RIDX_W    = 5;
  localparam int FUNCT3_W  = 3;
  localparam int ADDR_LO_W = 3;
  localparam int BE_W      = XLEN / 8;
  localparam int RAM_IDX_W = 10;
  localparam int RAM_DEPTH = 1 << RAM_IDX_W;

  typedef logic [XLEN-1:0]     xlen_t;
  typedef logic [INST_W-1:0]   inst_t;
  typedef logic [RIDX_W-1:0]   ridx_t;
  typedef logic [FUNCT3_W-1:0] funct3_t;

  // RV64I load encodings
  localparam funct3_t F3_LB  = 3'b000;
  localparam funct3_t F3_LH  = 3'b001;
  localparam funct3_t F3_LW  = 3'b010;
  localparam funct3_t F3_LD  = 3'b011;
  localparam funct3_t F3_LBU = 3'b100;
  localparam funct3_t F3_LHU = 3'b101;
  localparam funct3_t F3_LWU = 3'b110;

  // Access size lives in funct3[1:0] for both loads and stores
  localparam logic [1:0] SZ_BYTE   = 2'b00;
  localparam logic [1:0] SZ_HALF   = 2'b01;
  localparam logic [1:0] SZ_WORD   = 2'b10;
  localparam logic [1:0] SZ_DOUBLE = 2'b11;

  // One doubleword seen as byte, halfword, word or doubleword lanes
  typedef union packed {
    logic [7:0][7:0]  b;
    logic [3:0][15:0] h;
    logic [1:0][31:0] w;
    logic [63:0]      d;
  } mem_word_u;

  function automatic logic mem_is_aligned(funct3_t f3, logic [ADDR_LO_W-1:0] lo);
    case (f3[1:0])
      SZ_HALF:   return lo[0] == 1'b0;
      SZ_WORD:   return lo[1:0] == 2'b00;
      SZ_DOUBLE: return lo == 3'b000;
      default:   return 1'b1;
    endcase
  endfunction

endpackage

// ==== mem_stage_ctrl.sv ====
// Handshake control and pipeline register of the memory stage.
// Holds at most one item and offers it downstream until it is acked.
`timescale 1ns/1ps

module mem_stage_ctrl (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           i_executed_req,
  input  logic                           i_memoryed_ack,
  input  mem_pkg::xlen_t                 i_pc,
  input  mem_pkg::inst_t                 i_inst,
  input  logic [mem_pkg::ADDR_LO_W-1:0]  i_addr_lo,
  input  logic                           i_ren,
  input  mem_pkg::funct3_t               i_funct3,
  input  mem_pkg::ridx_t                 i_rd,
  input  logic                           i_rd_wen,
  input  mem_pkg::xlen_t                 i_rd_wdata,
  input  logic                           i_nocmt,
  input  logic                           i_skipcmt,
  output logic                           o_executed_ack,
  output logic                           o_memoryed_req,
  output logic                           o_accept,
  output mem_pkg::xlen_t                 o_pc,
  output mem_pkg::inst_t                 o_inst,
  output mem_pkg::ridx_t                 o_rd,
  output logic                           o_rd_wen,
  output mem_pkg::xlen_t                 o_rd_wdata,
  output logic                           o_nocmt,
  output logic                           o_skipcmt,
  output logic                           o_ld_valid,
  output logic [mem_pkg::ADDR_LO_W-1:0]  o_ld_addr_lo,
  output mem_pkg::funct3_t               o_ld_funct3
);
  import mem_pkg::*;

  logic                 valid_q;
  xlen_t                pc_q;
  inst_t                inst_q;
  logic [ADDR_LO_W-1:0] addr_lo_q;
  logic                 ren_q;
  funct3_t              funct3_q;
  ridx_t                rd_q;
  logic                 rd_wen_q;
  xlen_t                rd_wdata_q;
  logic                 nocmt_q;
  logic                 skipcmt_q;

  // Free slot, or the held item leaves in this same cycle
  assign o_executed_ack = !valid_q || i_memoryed_ack;
  assign o_accept       = i_executed_req && o_executed_ack;
  assign o_memoryed_req = valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (o_accept) begin
      valid_q <= 1'b1;
    end else if (i_memoryed_ack) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (o_accept) begin
      pc_q       <= i_pc;
      inst_q     <= i_inst;
      addr_lo_q  <= i_addr_lo;
      ren_q      <= i_ren;
      funct3_q   <= i_funct3;
      rd_q       <= i_rd;
      rd_wen_q   <= i_rd_wen;
      rd_wdata_q <= i_rd_wdata;
      nocmt_q    <= i_nocmt;
      skipcmt_q  <= i_skipcmt;
    end
  end

  assign o_pc         = valid_q ? pc_q : '0;
  assign o_inst       = valid_q ? inst_q : '0;
  assign o_rd         = valid_q ? rd_q : '0;
  assign o_rd_wen     = valid_q && rd_wen_q;
  assign o_rd_wdata   = valid_q ? rd_wdata_q : '0;
  assign o_nocmt      = valid_q && nocmt_q;
  assign o_skipcmt    = valid_q && skipcmt_q;
  assign o_ld_valid   = valid_q && ren_q;
  assign o_ld_addr_lo = addr_lo_q;
  assign o_ld_funct3  = funct3_q;

  // ##########################################################
  // A held result stays put until the downstream takes it
  req_held: assert property (@(posedge clk) disable iff (rst)
    o_memoryed_req && !i_memoryed_ack |=> o_memoryed_req);

  fields_held: assert property (@(posedge clk) disable iff (rst)
    o_memoryed_req && !i_memoryed_ack |=>
      $stable({pc_q, inst_q, addr_lo_q, ren_q, funct3_q, rd_q,
               rd_wen_q, rd_wdata_q, nocmt_q, skipcmt_q}));

endmodule

// ==== mem_stage_top.sv ====
// Memory stage top: handshake control around store align, data RAM and load extract.
// Address bits above the RAM index are ignored, so the RAM aliases.
`timescale 1ns/1ps

module mem_stage_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_executed_req,
  output logic              o_executed_ack,
  output logic              o_memoryed_req,
  input  logic              i_memoryed_ack,
  input  mem_pkg::xlen_t    i_pc,
  input  mem_pkg::inst_t    i_inst,
  input  mem_pkg::xlen_t    i_addr,
  input  logic              i_ren,
  input  mem_pkg::funct3_t  i_funct3,
  input  logic              i_wen,
  input  mem_pkg::xlen_t    i_wdata,
  input  mem_pkg::ridx_t    i_rd,
  input  logic              i_rd_wen,
  input  mem_pkg::xlen_t    i_rd_wdata,
  input  logic              i_nocmt,
  input  logic              i_skipcmt,
  output mem_pkg::xlen_t    o_pc,
  output mem_pkg::inst_t    o_inst,
  output mem_pkg::ridx_t    o_rd,
  output logic              o_rd_wen,
  output mem_pkg::xlen_t    o_rd_wdata,
  output mem_pkg::xlen_t    o_rdata,
  output logic              o_nocmt,
  output logic              o_skipcmt
);
  import mem_pkg::*;

  logic                 accept;
  logic                 ld_valid;
  logic [ADDR_LO_W-1:0] ld_addr_lo;
  funct3_t              ld_funct3;
  logic [BE_W-1:0]      be;
  mem_word_u            wword;
  mem_word_u            rword;

  mem_stage_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .i_executed_req (i_executed_req),
    .i_memoryed_ack (i_memoryed_ack),
    .i_pc           (i_pc),
    .i_inst         (i_inst),
    .i_addr_lo      (i_addr[ADDR_LO_W-1:0]),
    .i_ren          (i_ren),
    .i_funct3       (i_funct3),
    .i_rd           (i_rd),
    .i_rd_wen       (i_rd_wen),
    .i_rd_wdata     (i_rd_wdata),
    .i_nocmt        (i_nocmt),
    .i_skipcmt      (i_skipcmt),
    .o_executed_ack (o_executed_ack),
    .o_memoryed_req (o_memoryed_req),
    .o_accept       (accept),
    .o_pc           (o_pc),
    .o_inst         (o_inst),
    .o_rd           (o_rd),
    .o_rd_wen       (o_rd_wen),
    .o_rd_wdata     (o_rd_wdata),
    .o_nocmt        (o_nocmt),
    .o_skipcmt      (o_skipcmt),
    .o_ld_valid     (ld_valid),
    .o_ld_addr_lo   (ld_addr_lo),
    .o_ld_funct3    (ld_funct3)
  );

  mem_store_align u_store_align (
    .i_accept  (accept),
    .i_wen     (i_wen),
    .i_addr_lo (i_addr[ADDR_LO_W-1:0]),
    .i_funct3  (i_funct3),
    .i_wdata   (i_wdata),
    .o_be      (be),
    .o_wword   (wword)
  );

  mem_data_ram u_data_ram (
    .clk      (clk),
    .i_accept (accept),
    .i_ren    (i_ren),
    .i_idx    (i_addr[RAM_IDX_W+ADDR_LO_W-1:ADDR_LO_W]),
    .i_be     (be),
    .i_wword  (wword),
    .o_rword  (rword)
  );

  mem_load_extract u_load_extract (
    .i_ld_valid (ld_valid),
    .i_addr_lo  (ld_addr_lo),
    .i_funct3   (ld_funct3),
    .i_rword    (rword),
    .o_rdata    (o_rdata)
  );

endmodule

// ==== mem_store_align.sv ====
// Store alignment: moves store data into its byte lanes and builds byte enables.
`timescale 1ns/1ps

module mem_store_align (
  input  logic                           i_accept,
  input  logic                           i_wen,
  input  logic [mem_pkg::ADDR_LO_W-1:0]  i_addr_lo,
  input  mem_pkg::funct3_t               i_funct3,
  input  mem_pkg::xlen_t                 i_wdata,
  output logic [mem_pkg::BE_W-1:0]       o_be,
  output mem_pkg::mem_word_u             o_wword
);
  import mem_pkg::*;

  logic [BE_W-1:0] lane_be;

  // The data is copied into every lane of its size and the enables pick one
  always_comb begin
    o_wword = '0;
    lane_be = '0;
    case (i_funct3[1:0])
      SZ_BYTE: begin
        o_wword.b = {8{i_wdata[7:0]}};
        lane_be   = 8'b0000_0001 << i_addr_lo;
      end
      SZ_HALF: begin
        o_wword.h = {4{i_wdata[15:0]}};
        lane_be   = 8'b0000_0011 << {i_addr_lo[2:1], 1'b0};
      end
      SZ_WORD: begin
        o_wword.w = {2{i_wdata[31:0]}};
        lane_be   = 8'b0000_1111 << {i_addr_lo[2], 2'b00};
      end
      default: begin
        o_wword.d = i_wdata;
        lane_be   = 8'b1111_1111;
      end
    endcase
  end

  assign o_be = (i_accept && i_wen) ? lane_be : '0;

  // Misaligned stores are outside this design
  always_comb begin
    if (i_accept && i_wen) begin
      store_aligned: assert final (mem_is_aligned(i_funct3, i_addr_lo));
    end
  end

endmodule

// ==== tb.f ====
mem_pkg.sv
mem_stage_ctrl.sv
mem_store_align.sv
mem_data_ram.sv
mem_load_extract.sv
mem_stage_top.sv
tb_mem_stage.sv

// ==== tb_mem_stage.sv ====
// Random testbench for the memory stage with LFSR stimulus and handshake back-pressure.
// Results are checked against a reference memory and an expected-result queue.
`timescale 1ns/1ps

module tb_mem_stage;
  import mem_pkg::*;

  localparam int WIN         = 64;
  localparam int RAND_CYCLES = 800;
  localparam int FULL_CYCLES = 32;
  localparam int STALL_MAX   = 64;
  localparam int DRAIN_MAX   = 16;
  localparam int MODE_FILL   = 0;
  localparam int MODE_RAND   = 1;
  localparam int MODE_FULL   = 2;
  localparam int MODE_DRAIN  = 3;

  typedef struct packed {
    xlen_t pc;
    inst_t inst;
    ridx_t rd;
    logic  rd_wen;
    xlen_t rd_wdata;
    xlen_t rdata;
    logic  nocmt;
    logic  skipcmt;
    logic  is_load;
  } exp_t;

  logic clk, rst, i_executed_req, i_memoryed_ack, i_ren, i_wen;
  logic i_rd_wen, i_nocmt, i_skipcmt, o_executed_ack, o_memoryed_req;
  logic o_rd_wen, o_nocmt, o_skipcmt;
  xlen_t i_pc, i_addr, i_wdata, i_rd_wdata, o_pc, o_rd_wdata, o_rdata;
  inst_t i_inst, o_inst;
  ridx_t i_rd, o_rd;
  funct3_t i_funct3;

  logic [31:0] lfsr = 32'h40c3;
  logic [63:0] ref_mem [WIN];
  exp_t exp_q[$];
  logic model_valid, up_xfer, timed_out;
  logic [5:0] last_store_idx;
  int errors, done_cnt, load_cnt, stall_cnt, fill_idx;

  mem_stage_top dut_i (.*);

  always #5 clk = ~clk;

  // ##########################################################
  // Stimulus source and reference rules

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic xlen_t load_model(logic [63:0] dw, logic [2:0] lo, funct3_t f3);
    logic [63:0] sh;
    sh = dw >> (8 * lo);
    case (f3)
      F3_LB:   return {{56{sh[7]}}, sh[7:0]};
      F3_LBU:  return {56'd0, sh[7:0]};
      F3_LH:   return {{48{sh[15]}}, sh[15:0]};
      F3_LHU:  return {48'd0, sh[15:0]};
      F3_LW:   return {{32{sh[31]}}, sh[31:0]};
      F3_LWU:  return {32'd0, sh[31:0]};
      default: return sh;
    endcase
  endfunction

  task automatic check_xlen(string name, xlen_t got, xlen_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_inst(string name, inst_t got, inst_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_ridx(string name, ridx_t got, ridx_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_result(exp_t e);
    check_xlen("o_pc", o_pc, e.pc);
    check_inst("o_inst", o_inst, e.inst);
    check_ridx("o_rd", o_rd, e.rd);
    check_bit("o_rd_wen", o_rd_wen, e.rd_wen);
    check_xlen("o_rd_wdata", o_rd_wdata, e.rd_wdata);
    check_xlen("o_rdata", o_rdata, e.rdata);
    check_bit("o_nocmt", o_nocmt, e.nocmt);
    check_bit("o_skipcmt", o_skipcmt, e.skipcmt);
  endtask

  // ##########################################################
  // Everything is sampled at the falling edge when inputs and outputs have settled

  task automatic observe();
    exp_t e;
    logic [5:0] idx;
    logic [2:0] lo;
    up_xfer = i_executed_req && o_executed_ack;
    check_bit("o_memoryed_req", o_memoryed_req, model_valid);
    check_bit("o_executed_ack", o_executed_ack, !model_valid || i_memoryed_ack);
    if (!o_memoryed_req) begin
      compare_result('0);
    end else if (exp_q.size() == 0) begin
      $display("Result offered downstream with no matching upstream transfer");
      errors++;
    end else begin
      compare_result(exp_q[0]);
      if (i_memoryed_ack) begin
        load_cnt += exp_q[0].is_load;
        done_cnt++;
        void'(exp_q.pop_front());
      end
    end
    if (up_xfer) begin
      idx = i_addr[8:3];
      lo  = i_addr[2:0];
      if (i_wen) begin
        for (int i = 0; i < (1 << i_funct3[1:0]); i++) begin
          ref_mem[idx][8*(lo+i) +: 8] = i_wdata[8*i +: 8];
        end
      end
      e = '{i_pc, i_inst, i_rd, i_rd_wen, i_rd_wdata, '0, i_nocmt, i_skipcmt, i_ren};
      if (i_ren) begin
        e.rdata = load_model(ref_mem[idx], lo, i_funct3);
      end
      exp_q.push_back(e);
    end
    model_valid = up_xfer || (model_valid && !i_memoryed_ack);
  endtask

  // Kind 0 and 1 load, 2 stores, 3 touches no memory
  task automatic make_item(logic fill);
    logic [1:0] kind;
    logic [5:0] idx;
    logic [2:0] lo;
    funct3_t f3;
    kind = fill ? 2'd2 : 2'(rand_bits(2));
    f3 = F3_LD;
    idx = 6'(fill_idx);
    lo = 3'd0;
    if (!fill) begin
      f3 = 3'(rand_bits(3));
      if (kind == 2'd2) f3[2] = 1'b0;
      if (f3 == 3'b111) f3 = F3_LD;
      idx = (kind != 2'd2 && 1'(rand_bits(1))) ? last_store_idx : 6'(rand_bits(6));
      lo = 3'(rand_bits(3)) & (3'b111 << f3[1:0]);
    end
    if (kind == 2'd2) last_store_idx = idx;
    i_ren      = kind < 2'd2;
    i_wen      = kind == 2'd2;
    i_funct3   = f3;
    i_addr     = {51'(rand_bits(51)), 4'b0000, idx, lo};
    i_wdata    = rand_bits(64);
    i_pc       = rand_bits(64);
    i_inst     = 32'(rand_bits(32));
    i_rd       = 5'(rand_bits(5));
    i_rd_wen   = 1'(rand_bits(1));
    i_rd_wdata = rand_bits(64);
    i_nocmt    = 1'(rand_bits(1));
    i_skipcmt  = 1'(rand_bits(1));
    i_executed_req = 1'b1;
  endtask

  task automatic drive(int mode);
    if (up_xfer) begin
      i_executed_req = 1'b0;
      stall_cnt = 0;
    end else if (i_executed_req) begin
      stall_cnt++;
      if (stall_cnt > STALL_MAX) begin
        $display("Timeout: upstream request was never acknowledged");
        timed_out = 1'b1;
      end
    end
    if (!i_executed_req) begin
      if (mode == MODE_FILL && fill_idx < WIN) begin
        make_item(1'b1);
        fill_idx++;
      end else if (mode == MODE_FULL || (mode == MODE_RAND && 1'(rand_bits(1)))) begin
        make_item(1'b0);
      end
    end
    i_memoryed_ack = (mode == MODE_RAND) ? 1'(rand_bits(1)) : 1'b1;
  endtask

  task automatic step_cycle(int mode);
    @(negedge clk);
    observe();
    @(posedge clk);
    #1;
    drive(mode);
  endtask

  initial begin
    int start;
    int wait_cnt;
    {clk, i_executed_req, i_memoryed_ack, i_ren, i_wen, i_rd_wen, i_nocmt, i_skipcmt} = '0;
    {i_pc, i_addr, i_wdata, i_rd_wdata, i_inst, i_rd, i_funct3} = '0;
    {model_valid, up_xfer, timed_out, last_store_idx} = '0;
    {errors, done_cnt, load_cnt, stall_cnt, fill_idx} = '0;
    for (int i = 0; i < WIN; i++) ref_mem[i] = '0;
    rst = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int c = 0; c < WIN + 2 && !timed_out; c++) step_cycle(MODE_FILL);
    for (int c = 0; c < RAND_CYCLES && !timed_out; c++) step_cycle(MODE_RAND);
    start = done_cnt;
    for (int c = 0; c < FULL_CYCLES && !timed_out; c++) step_cycle(MODE_FULL);
    if (!timed_out && done_cnt - start < FULL_CYCLES - 2) begin
      $display("Throughput too low: %0d results in %0d full-rate cycles",
               done_cnt - start, FULL_CYCLES);
      errors++;
    end
    wait_cnt = 0;
    while (!timed_out && (exp_q.size() != 0 || i_executed_req)) begin
      step_cycle(MODE_DRAIN);
      wait_cnt++;
      if (wait_cnt > DRAIN_MAX) begin
        $display("Timeout: %0d expected results never came out", exp_q.size());
        timed_out = 1'b1;
      end
    end
    $display("errors=%0d timeout=%0d results=%0d loads=%0d",
             errors, timed_out, done_cnt, load_cnt);
    if (errors == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
